// File: tests/bus_cases.txt
# op  arg_a  arg_b, both hex
# write addr data | read addr expected | fetch/fetchb pc instr | wuart count first | uartn count first | sink on 0 | key code 0 | irq expected 0 | ack 0 0 | idle cycles 0
write 1010 a1b2c3d4
read 1010 a1b2c3d4
read 3000 a1b2c3d4
write 0010 55aa55aa
read 0010 0
fetch 1010 d4c3b2a1
write 1020 00000013
fetchb 1020 13000000
sink 0 0
wuart 9 41
sink 1 0
uartn 8 41
key 0 0
idle 3 0
irq 0 0
key 31 0
key 32 0
idle 1 0
irq 1 0
read 2008 31
ack 0 0
idle 1 0
irq 1 0
read 2008 32
ack 0 0
idle 2 0
irq 0 0

// File: all.f
logic/soc_bus_pkg.sv
logic/soc_periph_pkg.sv
logic/event_fifo.sv
logic/onchip_ram.sv
logic/mem_arbiter.sv
logic/bus_decoder.sv
logic/key_irq_ctrl.sv
logic/soc_bus_top.sv
tests/soc_bus_checker.sv
tests/soc_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= soc_bus_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/soc_bus_tb.sv
`timescale 1ns/1ns

module soc_bus_tb;

    logic CLOCK_50;
    logic KEY0;
    soc_bus_pkg::bus_req_t bus_req;
    logic [63:0] bus_read_data;
    soc_bus_pkg::fetch_req_t fetch;
    logic [31:0] instr;
    logic fetch_valid;
    logic key_strobe;
    soc_periph_pkg::key_code_t key_code;
    logic [3:0] irq_vector;
    logic irq_ack;
    soc_periph_pkg::uart_byte_t uart_byte;
    logic uart_valid;
    logic uart_ready;

    string ops[$];
    logic [63:0] arg_a[$];
    logic [63:0] arg_b[$];
    logic [7:0] sink_q[$];
    logic [15:0] lfsr;
    logic sink_on;
    int errors;
    int checks;
    int cycles;
    int limit = 1000;

    soc_bus_top dut0 (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    // 16-bit Galois LFSR
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Random ready, one LFSR bit per cycle
    always @(posedge CLOCK_50) begin
        #2;
        uart_ready = sink_on & lfsr[0];
        lfsr = lfsr_step(lfsr);
    end

    // Console sink, a byte leaves on the coming edge
    always @(negedge CLOCK_50) begin
        if (KEY0 && uart_valid && uart_ready)
            sink_q.push_back(uart_byte);
    end

    // Run limit, raised once the cases are loaded
    initial begin
        cycles = 0;
        while (cycles < limit) begin
            @(posedge CLOCK_50);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles", cycles);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge CLOCK_50);
        #2;
    endtask

    task automatic bus_write(logic [63:0] addr, logic [63:0] data);
        bus_req.addr = addr;
        bus_req.wdata = data;
        bus_req.we = 1'b1;
        next_cycle();
        bus_req.we = 1'b0;
    endtask

    // Result is due exactly two edges after the strobe
    task automatic bus_read(logic [63:0] addr, logic [63:0] exp);
        bus_req.addr = addr;
        bus_req.re = 1'b1;
        next_cycle();
        bus_req.re = 1'b0;
        @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        check_value("bus_read_data", bus_read_data, exp);
        next_cycle();
    endtask

    // Optional data reads keep the port busy at the start
    task automatic do_fetch(logic [63:0] pc, logic [31:0] exp, int busy);
        int k;
        k = 0;
        fetch.req = 1'b1;
        fetch.pc = pc;
        if (busy > 0) begin
            bus_req.addr = soc_bus_pkg::ram_base;
            bus_req.re = 1'b1;
        end
        while (!fetch_valid) begin
            next_cycle();
            k++;
            if (k >= busy)
                bus_req.re = 1'b0;
        end
        check_value("instr", {32'd0, instr}, {32'd0, exp});
        fetch.req = 1'b0;
        next_cycle();
    endtask

    task automatic run_case(string op, logic [63:0] a, logic [63:0] b);
        logic raised;
        if (op == "write") bus_write(a, b);
        else if (op == "read") bus_read(a, b);
        else if (op == "fetch") do_fetch(a, b[31:0], 0);
        else if (op == "fetchb") do_fetch(a, b[31:0], 3);
        else if (op == "wuart") begin
            for (int i = 0; i < int'(a); i++)
                bus_write(soc_bus_pkg::uart_addr, b + 64'(i));
        end else if (op == "uartn") begin
            for (int i = 0; i < int'(a); i++) begin
                while (sink_q.size() == 0)
                    @(negedge CLOCK_50);
                check_value("uart_byte", {56'd0, sink_q.pop_front()}, b + 64'(i));
            end
            next_cycle();
        end else if (op == "sink") begin
            sink_on = a[0];
            next_cycle();
            next_cycle();
        end else if (op == "key") begin
            key_code = a[7:0];
            key_strobe = 1'b1;
            next_cycle();
            key_strobe = 1'b0;
        end else if (op == "ack") begin
            irq_ack = 1'b1;
            raised = (irq_vector != 4'd0);
            next_cycle();
            irq_ack = 1'b0;
            // Ack while raised clears the vector on the next edge
            if (raised)
                check_value("irq_vector", {60'd0, irq_vector}, 64'd0);
        end else if (op == "irq") check_value("irq_vector", {60'd0, irq_vector}, a);
        else if (op == "idle") repeat (int'(a)) next_cycle();
        else begin
            errors++;
            $display("Unknown operation %s in the cases file", op);
        end
    endtask

    initial begin
        int fd;
        string op;
        string rest;
        logic [63:0] a;
        logic [63:0] b;
        bus_req = '0;
        fetch = '0;
        key_strobe = 1'b0;
        key_code = '0;
        irq_ack = 1'b0;
        uart_ready = 1'b0;
        sink_on = 1'b1;
        lfsr = 16'd7470;
        KEY0 = 1'b0;
        errors = 0;
        checks = 0;
        fd = $fopen("tests/bus_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the cases file");
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else begin
                    void'($fscanf(fd, "%h %h", a, b));
                    ops.push_back(op);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                end
            end
            $fclose(fd);
        end
        limit = 20 * ops.size() + 200;
        repeat (3) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        check_value("irq_vector", {60'd0, irq_vector}, 64'd0);
        check_value("uart_valid", {63'd0, uart_valid}, 64'd0);
        check_value("fetch_valid", {63'd0, fetch_valid}, 64'd0);
        check_value("bus_read_data", bus_read_data, 64'd0);
        next_cycle();
        foreach (ops[i])
            run_case(ops[i], arg_a[i], arg_b[i]);
        repeat (10) next_cycle();
        // Nothing beyond the expected bytes may reach the console
        check_value("uart_leftover", 64'(sink_q.size()), 64'd0);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: tests/soc_bus_checker.sv
`timescale 1ns/1ns

module soc_bus_checker (
    input logic       CLOCK_50,
    input logic       KEY0,
    input logic       fetch_req,
    input logic       data_sel,
    input logic       fetch_valid,
    input logic       key_pop,
    input logic       key_full,
    input logic [3:0] irq_vector,
    input logic       irq_ack
);

    // fetch_valid only two cycles after a fetch found the port free
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        fetch_valid |-> $past(fetch_req && !data_sel, 2))
        else $error("fetch_valid without a granted fetch");

    // A full key queue stays full until popped, no push overflows it
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (key_full && !key_pop) |=> key_full)
        else $error("key queue left full state without a pop");

    // Interrupt held until acknowledged
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (irq_vector != 4'd0 && !irq_ack) |=> (irq_vector != 4'd0))
        else $error("irq_vector dropped without ack");

endmodule

bind mem_arbiter soc_bus_checker arb_chk0 (
    .CLOCK_50 (CLOCK_50), .KEY0 (KEY0), .fetch_req (fetch.req),
    .data_sel (data_sel), .fetch_valid (fetch_valid), .key_pop (1'b0),
    .key_full (1'b0), .irq_vector (4'd0), .irq_ack (1'b0)
);

bind key_irq_ctrl soc_bus_checker key_chk0 (
    .CLOCK_50 (CLOCK_50), .KEY0 (KEY0), .fetch_req (1'b0),
    .data_sel (1'b0), .fetch_valid (1'b0), .key_pop (key_pop),
    .key_full (key_full), .irq_vector (irq_vector), .irq_ack (irq_ack)
);

// File: logic/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  soc_bus_pkg::bus_req_t      bus_req,
    output logic [63:0]                bus_read_data,
    input  soc_bus_pkg::fetch_req_t    fetch,
    output logic [31:0]                instr,
    output logic                       fetch_valid,
    input  logic                       key_strobe,
    input  soc_periph_pkg::key_code_t  key_code,
    output logic [3:0]                 irq_vector,
    input  logic                       irq_ack,
    output soc_periph_pkg::uart_byte_t uart_byte,
    output logic                       uart_valid,
    input  logic                       uart_ready
);

    soc_bus_pkg::mem_cmd_t data_cmd;
    soc_bus_pkg::mem_cmd_t mem_cmd;
    logic data_sel;
    logic [31:0] mem_rdata;
    logic key_pop;
    soc_periph_pkg::key_code_t key_head;
    logic uart_push;
    soc_periph_pkg::uart_byte_t uart_data;

    mem_arbiter mem_arbiter0 (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .data_cmd    (data_cmd),
        .data_sel    (data_sel),
        .fetch       (fetch),
        .mem_cmd     (mem_cmd),
        .mem_rdata   (mem_rdata),
        .instr       (instr),
        .fetch_valid (fetch_valid)
    );

    onchip_ram onchip_ram0 (
        .CLOCK_50 (CLOCK_50),
        .cmd      (mem_cmd),
        .rdata    (mem_rdata)
    );

    bus_decoder bus_decoder0 (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .data_cmd      (data_cmd),
        .data_sel      (data_sel),
        .mem_rdata     (mem_rdata),
        .key_pop       (key_pop),
        .key_head      (key_head),
        .uart_push     (uart_push),
        .uart_data     (uart_data),
        .bus_read_data (bus_read_data)
    );

    key_irq_ctrl key_irq_ctrl0 (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .key_strobe (key_strobe),
        .key_code   (key_code),
        .key_pop    (key_pop),
        .key_head   (key_head),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack)
    );

    // Console queue, a byte leaves on each valid and ready edge
    event_fifo #(
        .payload_t (soc_periph_pkg::uart_byte_t),
        .depth     (soc_periph_pkg::uart_fifo_depth)
    ) uart_fifo0 (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .push      (uart_push),
        .din       (uart_data),
        .pop       (uart_valid && uart_ready),
        .dout      (uart_byte),
        .not_empty (uart_valid),
        .full      ()
    );

endmodule

// File: logic/key_irq_ctrl.sv
`timescale 1ns/1ns

module key_irq_ctrl (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  logic                      key_strobe,
    input  soc_periph_pkg::key_code_t key_code,
    input  logic                      key_pop,
    output soc_periph_pkg::key_code_t key_head,
    output logic [3:0]                irq_vector,
    input  logic                      irq_ack
);

    logic key_push;
    logic key_avail;
    logic key_full;

    // Zero codes carry no key, full queue drops the event
    assign key_push = key_strobe && (key_code != '0) && !key_full;

    event_fifo #(
        .payload_t (soc_periph_pkg::key_code_t),
        .depth     (soc_periph_pkg::key_fifo_depth)
    ) key_fifo0 (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .push      (key_push),
        .din       (key_code),
        .pop       (key_pop),
        .dout      (key_head),
        .not_empty (key_avail),
        .full      (key_full)
    );

    // One interrupt outstanding at a time
    // keyboard uses vector 1
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
        end else if (irq_vector != 4'd0) begin
            if (irq_ack)
                irq_vector <= 4'd0;
        end else if (key_avail) begin
            // Raised again after an ack while codes remain
            irq_vector <= 4'd1;
        end
    end

endmodule

// File: logic/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  soc_bus_pkg::bus_req_t      bus_req,
    output soc_bus_pkg::mem_cmd_t      data_cmd,
    output logic                       data_sel,
    input  logic [31:0]                mem_rdata,
    output logic                       key_pop,
    input  soc_periph_pkg::key_code_t  key_head,
    output logic                       uart_push,
    output soc_periph_pkg::uart_byte_t uart_data,
    output logic [63:0]                bus_read_data
);

    logic rom_sel;
    logic ram_sel;
    logic uart_sel;
    logic key_sel;
    logic mem_rd_d;
    logic key_rd_d;
    soc_periph_pkg::key_code_t key_hold;

    // Address decode
    assign rom_sel = (bus_req.addr >= soc_bus_pkg::rom_base) &&
                     (bus_req.addr < soc_bus_pkg::rom_base + soc_bus_pkg::rom_size);
    assign ram_sel = (bus_req.addr >= soc_bus_pkg::ram_base) &&
                     (bus_req.addr < soc_bus_pkg::ram_base + soc_bus_pkg::ram_size);
    assign uart_sel = (bus_req.addr == soc_bus_pkg::uart_addr);
    assign key_sel = (bus_req.addr == soc_bus_pkg::key_addr);

    // Memory access toward the arbiter, ROM writes are blocked in the RAM
    assign data_sel = (bus_req.re || bus_req.we) && (rom_sel || ram_sel);
    always_comb begin
        data_cmd.idx = bus_req.addr[soc_bus_pkg::mem_addr_bits+1:2];
        data_cmd.data = bus_req.wdata[31:0];
        data_cmd.we = bus_req.we;
    end

    // Peripheral strobes
    assign uart_push = bus_req.we && uart_sel;
    assign uart_data = bus_req.wdata[7:0];
    assign key_pop = bus_req.re && key_sel;

    // Queue head taken in the same cycle as its pop
    always_ff @(posedge CLOCK_50) begin
        if (key_pop)
            key_hold <= key_head;
    end

    // Select lines up with the RAM read latency
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mem_rd_d <= 1'b0;
            key_rd_d <= 1'b0;
        end else begin
            mem_rd_d <= bus_req.re && (rom_sel || ram_sel);
            key_rd_d <= key_pop;
        end
    end

    // Registered read mux, holds its value on unmapped reads
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_data <= 64'd0;
        end else if (mem_rd_d) begin
            bus_read_data <= {32'd0, mem_rdata};
        end else if (key_rd_d) begin
            bus_read_data <= {56'd0, key_hold};
        end
    end

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  soc_bus_pkg::mem_cmd_t   data_cmd,
    input  logic                    data_sel,
    input  soc_bus_pkg::fetch_req_t fetch,
    output soc_bus_pkg::mem_cmd_t   mem_cmd,
    input  logic [31:0]             mem_rdata,
    output logic [31:0]             instr,
    output logic                    fetch_valid
);

    soc_bus_pkg::mem_cmd_t fetch_cmd;
    logic fetch_busy;
    logic fetch_grant;
    logic fetch_rd;

    // Fetch is a plain read of the word at pc
    always_comb begin
        fetch_cmd.idx = fetch.pc[soc_bus_pkg::mem_addr_bits+1:2];
        fetch_cmd.data = 32'd0;
        fetch_cmd.we = 1'b0;
    end

    // One fetch in flight until its fetch_valid
    assign fetch_busy = fetch_rd || fetch_valid;

    // Data always wins the port
    assign fetch_grant = fetch.req && !data_sel && !fetch_busy;

    assign mem_cmd = data_sel ? data_cmd : fetch_cmd;

    // Stage one marks read data on mem_rdata, stage two is fetch_valid
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            fetch_rd <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_rd <= fetch_grant;
            fetch_valid <= fetch_rd;
        end
    end

    // Memory is little endian, the core wants bytes reversed
    always_ff @(posedge CLOCK_50) begin
        if (fetch_rd)
            instr <= {mem_rdata[7:0], mem_rdata[15:8], mem_rdata[23:16], mem_rdata[31:24]};
    end

endmodule

// File: logic/onchip_ram.sv
`timescale 1ns/1ns

module onchip_ram (
    input  logic                  CLOCK_50,
    input  soc_bus_pkg::mem_cmd_t cmd,
    output logic [31:0]           rdata
);

    logic [31:0] mem [soc_bus_pkg::mem_words];
    logic ram_hit;

    // Top index bit splits ROM (low half) from RAM
    assign ram_hit = cmd.idx[soc_bus_pkg::mem_addr_bits-1];

    // ROM is never written and reads back as zero
    always_ff @(posedge CLOCK_50) begin
        if (cmd.we && ram_hit)
            mem[cmd.idx] <= cmd.data;
        // Read returns the old word during a write
        if (ram_hit)
            rdata <= mem[cmd.idx];
        else
            rdata <= 32'd0;
    end

endmodule

// File: logic/event_fifo.sv
`timescale 1ns/1ns

module event_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 4
) (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     not_empty,
    output logic     full
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_bits = $clog2(depth + 1);

    payload_t slots [depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;
    logic do_push;
    logic do_pop;

    assign not_empty = (count != '0);
    assign full = (count == cnt_bits'(depth));

    // Full pushes and empty pops are ignored
    assign do_push = push && !full;
    assign do_pop = pop && not_empty;

    // Head is visible without a pop
    assign dout = slots[rd_ptr];

    always_ff @(posedge CLOCK_50) begin
        if (do_push)
            slots[wr_ptr] <= din;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

// File: logic/soc_periph_pkg.sv
package soc_periph_pkg;

    // Key code from the keyboard decoder, zero means no key
    typedef logic [7:0] key_code_t;

    // Byte bound for the console
    typedef logic [7:0] uart_byte_t;

    // Queue sizes
    localparam int key_fifo_depth = 4;
    localparam int uart_fifo_depth = 8;

endpackage

// File: logic/soc_bus_pkg.sv
package soc_bus_pkg;

    // Memory map, byte addresses
    localparam logic [63:0] rom_base = 64'h0000_0000_0000_0000;
    localparam logic [63:0] rom_size = 64'h0000_0000_0000_1000;
    localparam logic [63:0] ram_base = 64'h0000_0000_0000_1000;
    localparam logic [63:0] ram_size = 64'h0000_0000_0000_1000;

    // Peripheral registers
    localparam logic [63:0] uart_addr = 64'h0000_0000_0000_2000;
    localparam logic [63:0] key_addr = 64'h0000_0000_0000_2008;

    // 8 KB of 32-bit words, ROM in the low half
    localparam int mem_words = 2048;
    localparam int mem_addr_bits = 11;

    // Data bus request from the core
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic we;
        logic re;
    } bus_req_t;

    // Instruction fetch, held until fetch_valid
    typedef struct packed {
        logic req;
        logic [63:0] pc;
    } fetch_req_t;

    // One access on the memory port
    typedef struct packed {
        logic [mem_addr_bits-1:0] idx;
        logic [31:0] data;
        logic we;
    } mem_cmd_t;

endpackage
